//--- source/swervolf_pkg.sv
// Shared definitions for the peripheral subsystem
// Bus word types, address map, register offsets, display sizing
// Bridge and decoder state encodings, byte-lane merge helper

`default_nettype none

package swervolf_pkg;

   typedef logic [31:0] data_t;
   typedef logic [15:0] addr_t;
   typedef logic [3:0]  sel_t;
   typedef logic [31:0] gpio_t;
   typedef logic [1:0]  sw_irq_t;

   // Boot ROM
   localparam int ROM_WORDS    = 16;
   localparam     BOOTROM_FILE = "bootrom.hex";

   // Address map, matched against address bits 15:12
   localparam logic [3:0] REGION_ROM = 4'd0;
   localparam logic [3:0] REGION_SYS = 4'd1;
   localparam logic [3:0] REGION_SSD = 4'd2;

   // System controller registers
   localparam logic [7:0] SYS_GPIO_OUT = 8'h00;
   localparam logic [7:0] SYS_GPIO_IN  = 8'h04;
   localparam logic [7:0] SYS_SW_IRQ   = 8'h08;
   localparam logic [7:0] SYS_MTIME    = 8'h0C;
   localparam logic [7:0] SYS_MTIMECMP = 8'h10;

   // Seven-segment display
   localparam logic [7:0] SSD_DIGITS_REG = 8'h00;
   localparam int         SSD_NUM_DIGITS = 8;
   localparam int         SCAN_DIV_BITS  = 4;

   typedef enum logic [1:0] {BR_IDLE, BR_BUS, BR_RESP} bridge_state_e;
   typedef enum logic [1:0] {SLV_ROM, SLV_SYS, SLV_SSD, SLV_NONE} slave_e;

   // Replace only the byte lanes enabled in sel
   function automatic data_t merge_lanes(data_t old_val, data_t new_val, sel_t sel);
      data_t res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (sel[b])
            res[8*b +: 8] = new_val[8*b +: 8];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

//--- source/host_bridge.sv
// Host to internal bus bridge
// Four-phase req/ack port in, one Wishbone-style cycle out

`timescale 1ns/100ps
`default_nettype none

module host_bridge import swervolf_pkg::*; (
   input  wire   i_clk,
   input  wire   i_arst_n,
   // Host side
   input  wire   i_req,
   input  wire   i_we,
   input  addr_t i_addr,
   input  data_t i_wdata,
   input  sel_t  i_sel,
   output logic  o_ack,
   output logic  o_err,
   output data_t o_rdata,
   // Internal bus side
   output logic  o_bus_cyc,
   output logic  o_bus_stb,
   output logic  o_bus_we,
   output addr_t o_bus_adr,
   output data_t o_bus_dat,
   output sel_t  o_bus_sel,
   input  data_t i_bus_rdat,
   input  wire   i_bus_ack,
   input  wire   i_bus_err
);

   bridge_state_e state;

   //**************************************************
   // Control FSM
   //**************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state     <= BR_IDLE;
         o_bus_cyc <= 1'b0;
         o_bus_stb <= 1'b0;
         o_ack     <= 1'b0;
         o_err     <= 1'b0;
      end else begin
         case (state)
            BR_IDLE: begin
               if (i_req) begin
                  o_bus_cyc <= 1'b1;
                  o_bus_stb <= 1'b1;
                  state     <= BR_BUS;
               end
            end
            BR_BUS: begin
               if (i_bus_ack || i_bus_err) begin
                  o_bus_cyc <= 1'b0;
                  o_bus_stb <= 1'b0;
                  o_ack     <= 1'b1;
                  o_err     <= i_bus_err;
                  state     <= BR_RESP;
               end
            end
            // Hold the response until the host lets go of req
            BR_RESP: begin
               if (!i_req) begin
                  o_ack <= 1'b0;
                  o_err <= 1'b0;
                  state <= BR_IDLE;
               end
            end
            default: state <= BR_IDLE;
         endcase
      end
   end

   // Request capture and read data
   always_ff @(posedge i_clk) begin
      if (state == BR_IDLE && i_req) begin
         o_bus_we  <= i_we;
         o_bus_adr <= i_addr;
         o_bus_dat <= i_wdata;
         o_bus_sel <= i_sel;
      end
      if (state == BR_BUS && (i_bus_ack || i_bus_err))
         o_rdata <= i_bus_rdat;
   end

   // A slave answers only while the bridge has a cycle open
   resp_in_bus: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (i_bus_ack || i_bus_err) |-> state == BR_BUS);

endmodule

`default_nettype wire

//--- source/bus_decoder.sv
// Internal bus address decoder
// Slave select, strobe gating, return mux, error for unmapped space

`timescale 1ns/100ps
`default_nettype none

module bus_decoder import swervolf_pkg::*; (
   input  wire   i_cyc,
   input  wire   i_stb,
   input  addr_t i_adr,
   // Slave returns
   input  data_t i_rom_rdat,
   input  wire   i_rom_ack,
   input  data_t i_sys_rdat,
   input  wire   i_sys_ack,
   input  data_t i_ssd_rdat,
   input  wire   i_ssd_ack,
   // Slave strobes
   output logic  o_rom_stb,
   output logic  o_sys_stb,
   output logic  o_ssd_stb,
   // Back to the bridge
   output data_t o_rdat,
   output logic  o_ack,
   output logic  o_err
);

   slave_e slave;

   // Region from the top address nibble
   always_comb begin
      case (i_adr[15:12])
         REGION_ROM: slave = SLV_ROM;
         REGION_SYS: slave = SLV_SYS;
         REGION_SSD: slave = SLV_SSD;
         default:    slave = SLV_NONE;
      endcase
   end

   assign o_rom_stb = i_stb && (slave == SLV_ROM);
   assign o_sys_stb = i_stb && (slave == SLV_SYS);
   assign o_ssd_stb = i_stb && (slave == SLV_SSD);

   // Unmapped accesses are answered here, in the strobe cycle
   assign o_err = i_cyc && i_stb && (slave == SLV_NONE);

   always_comb begin
      case (slave)
         SLV_ROM: begin
            o_rdat = i_rom_rdat;
            o_ack  = i_rom_ack;
         end
         SLV_SYS: begin
            o_rdat = i_sys_rdat;
            o_ack  = i_sys_ack;
         end
         SLV_SSD: begin
            o_rdat = i_ssd_rdat;
            o_ack  = i_ssd_ack;
         end
         default: begin
            o_rdat = '0;
            o_ack  = 1'b0;
         end
      endcase
   end

   always_comb begin
      stb_onehot: assert #0 ($onehot0({o_rom_stb, o_sys_stb, o_ssd_stb}));
   end

endmodule

`default_nettype wire

//--- source/boot_rom.sv
// Boot ROM slave
// Word memory loaded from the boot image, single-cycle ack

`timescale 1ns/100ps
`default_nettype none

module boot_rom import swervolf_pkg::*; (
   input  wire                           i_clk,
   input  wire                           i_arst_n,
   input  wire                           i_stb,
   input  wire                           i_cyc,
   input  wire [$clog2(ROM_WORDS)-1:0]   i_word,
   output data_t                         o_rdat,
   output logic                          o_ack
);

   data_t mem [ROM_WORDS];

   initial begin
      $readmemh(BOOTROM_FILE, mem);
   end

   // Writes get an ack like reads but never touch the array
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_ack <= 1'b0;
      else
         o_ack <= i_stb && i_cyc && !o_ack;
   end

   always_ff @(posedge i_clk) begin
      o_rdat <= mem[i_word];
   end

endmodule

`default_nettype wire

//--- source/swervolf_syscon.sv
// System controller slave
// GPIO out/in, software interrupt bits, mtime and mtimecmp
// Registered timer interrupt

`timescale 1ns/100ps
`default_nettype none

module swervolf_syscon import swervolf_pkg::*; (
   input  wire        i_clk,
   input  wire        i_arst_n,
   input  wire        i_stb,
   input  wire        i_cyc,
   input  wire        i_we,
   input  wire  [7:0] i_offset,
   input  data_t      i_wdat,
   input  sel_t       i_sel,
   input  gpio_t      i_gpio,
   output data_t      o_rdat,
   output logic       o_ack,
   output gpio_t      o_gpio,
   output sw_irq_t    o_sw_irq,
   output logic       o_timer_irq
);

   data_t mtime;
   data_t mtimecmp;
   data_t rd_mux;
   logic  start;
   logic  wr_en;

   // First cycle of an access only
   assign start = i_stb && i_cyc && !o_ack;
   assign wr_en = start && i_we;

   //**************************************************
   // Registers
   //**************************************************
   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack       <= 1'b0;
         o_gpio      <= '0;
         o_sw_irq    <= '0;
         mtime       <= '0;
         mtimecmp    <= '1;
         o_timer_irq <= 1'b0;
      end else begin
         o_ack <= start;
         mtime <= mtime + 1'b1;
         // Compare sees the mtimecmp value from the previous edge
         o_timer_irq <= (mtime >= mtimecmp);
         if (wr_en) begin
            case (i_offset)
               SYS_GPIO_OUT: o_gpio <= merge_lanes(o_gpio, i_wdat, i_sel);
               SYS_SW_IRQ: begin
                  if (i_sel[0])
                     o_sw_irq <= i_wdat[1:0];
               end
               SYS_MTIMECMP: mtimecmp <= merge_lanes(mtimecmp, i_wdat, i_sel);
               default: ;
            endcase
         end
      end
   end

   //**************************************************
   // Read path
   //**************************************************
   always_comb begin
      case (i_offset)
         SYS_GPIO_OUT: rd_mux = o_gpio;
         SYS_GPIO_IN:  rd_mux = i_gpio;
         SYS_SW_IRQ:   rd_mux = {30'd0, o_sw_irq};
         SYS_MTIME:    rd_mux = mtime;
         SYS_MTIMECMP: rd_mux = mtimecmp;
         default:      rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (start)
         o_rdat <= rd_mux;
   end

   ack_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      o_ack |=> !o_ack);

endmodule

`default_nettype wire

//--- source/ssd_controller.sv
// Seven-segment display slave
// Digit register, digit scan counter, hex font decode

`timescale 1ns/100ps
`default_nettype none

module ssd_controller import swervolf_pkg::*; (
   input  wire                        i_clk,
   input  wire                        i_arst_n,
   input  wire                        i_stb,
   input  wire                        i_cyc,
   input  wire                        i_we,
   input  data_t                      i_wdat,
   input  sel_t                       i_sel,
   output data_t                      o_rdat,
   output logic                       o_ack,
   output logic [SSD_NUM_DIGITS-1:0]  o_anode,
   output logic [7:0]                 o_cathode
);

   data_t                                          digits;
   logic [SCAN_DIV_BITS+$clog2(SSD_NUM_DIGITS)-1:0] scan_cnt;
   logic [$clog2(SSD_NUM_DIGITS)-1:0]               digit_sel;
   logic [3:0]                                     nibble;
   logic [6:0]                                     segments;
   logic                                           start;

   assign start = i_stb && i_cyc && !o_ack;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack    <= 1'b0;
         digits   <= '0;
         scan_cnt <= '0;
      end else begin
         o_ack    <= start;
         scan_cnt <= scan_cnt + 1'b1;
         if (start && i_we)
            digits <= merge_lanes(digits, i_wdat, i_sel);
      end
   end

   always_ff @(posedge i_clk) begin
      if (start)
         o_rdat <= digits;
   end

   //**************************************************
   // Digit scan and segment decode
   //**************************************************
   // Top counter bits pick the digit, low bits set dwell time
   assign digit_sel = scan_cnt[$high(scan_cnt) -: $clog2(SSD_NUM_DIGITS)];
   assign nibble    = digits[4*digit_sel +: 4];
   assign o_anode   = ~({{(SSD_NUM_DIGITS-1){1'b0}}, 1'b1} << digit_sel);

   // Segments g..a, active high here
   always_comb begin
      case (nibble)
         4'h0: segments = 7'h3F;
         4'h1: segments = 7'h06;
         4'h2: segments = 7'h5B;
         4'h3: segments = 7'h4F;
         4'h4: segments = 7'h66;
         4'h5: segments = 7'h6D;
         4'h6: segments = 7'h7D;
         4'h7: segments = 7'h07;
         4'h8: segments = 7'h7F;
         4'h9: segments = 7'h6F;
         4'hA: segments = 7'h77;
         4'hB: segments = 7'h7C;
         4'hC: segments = 7'h39;
         4'hD: segments = 7'h5E;
         4'hE: segments = 7'h79;
         default: segments = 7'h71;
      endcase
   end

   // Decimal point stays dark
   assign o_cathode = {1'b1, ~segments};

   one_anode: assert property (@(posedge i_clk) disable iff (!i_arst_n)
      $onehot(~o_anode));

endmodule

`default_nettype wire

//--- source/swervolf_core.sv
// Peripheral subsystem top level
// Host bridge, address decoder, boot ROM, system controller, display

`timescale 1ns/100ps
`default_nettype none

module swervolf_core import swervolf_pkg::*; (
   input  wire        i_clk,
   input  wire        i_arst_n,
   // Host port
   input  wire        i_req,
   input  wire        i_we,
   input  addr_t      i_addr,
   input  data_t      i_wdata,
   input  sel_t       i_sel,
   output logic       o_ack,
   output logic       o_err,
   output data_t      o_rdata,
   // Pins
   input  gpio_t      i_gpio,
   output gpio_t      o_gpio,
   output logic       o_timer_irq,
   output sw_irq_t    o_sw_irq,
   output logic [7:0] o_anode,
   output logic [7:0] o_cathode
);

   // Shared bus from the bridge
   logic  bus_cyc;
   logic  bus_stb;
   logic  bus_we;
   addr_t bus_adr;
   data_t bus_dat_w;
   sel_t  bus_sel;
   data_t bus_dat_r;
   logic  bus_ack;
   logic  bus_err;

   // Per-slave strobes and returns
   logic  rom_stb;
   logic  sys_stb;
   logic  ssd_stb;
   data_t rom_rdat;
   data_t sys_rdat;
   data_t ssd_rdat;
   logic  rom_ack;
   logic  sys_ack;
   logic  ssd_ack;

   host_bridge u_bridge (
      .i_clk      (i_clk),
      .i_arst_n   (i_arst_n),
      .i_req      (i_req),
      .i_we       (i_we),
      .i_addr     (i_addr),
      .i_wdata    (i_wdata),
      .i_sel      (i_sel),
      .o_ack      (o_ack),
      .o_err      (o_err),
      .o_rdata    (o_rdata),
      .o_bus_cyc  (bus_cyc),
      .o_bus_stb  (bus_stb),
      .o_bus_we   (bus_we),
      .o_bus_adr  (bus_adr),
      .o_bus_dat  (bus_dat_w),
      .o_bus_sel  (bus_sel),
      .i_bus_rdat (bus_dat_r),
      .i_bus_ack  (bus_ack),
      .i_bus_err  (bus_err)
   );

   bus_decoder u_decoder (
      .i_cyc      (bus_cyc),
      .i_stb      (bus_stb),
      .i_adr      (bus_adr),
      .i_rom_rdat (rom_rdat),
      .i_rom_ack  (rom_ack),
      .i_sys_rdat (sys_rdat),
      .i_sys_ack  (sys_ack),
      .i_ssd_rdat (ssd_rdat),
      .i_ssd_ack  (ssd_ack),
      .o_rom_stb  (rom_stb),
      .o_sys_stb  (sys_stb),
      .o_ssd_stb  (ssd_stb),
      .o_rdat     (bus_dat_r),
      .o_ack      (bus_ack),
      .o_err      (bus_err)
   );

   boot_rom u_bootrom (
      .i_clk    (i_clk),
      .i_arst_n (i_arst_n),
      .i_stb    (rom_stb),
      .i_cyc    (bus_cyc),
      .i_word   (bus_adr[5:2]),
      .o_rdat   (rom_rdat),
      .o_ack    (rom_ack)
   );

   swervolf_syscon u_syscon (
      .i_clk       (i_clk),
      .i_arst_n    (i_arst_n),
      .i_stb       (sys_stb),
      .i_cyc       (bus_cyc),
      .i_we        (bus_we),
      .i_offset    (bus_adr[7:0]),
      .i_wdat      (bus_dat_w),
      .i_sel       (bus_sel),
      .i_gpio      (i_gpio),
      .o_rdat      (sys_rdat),
      .o_ack       (sys_ack),
      .o_gpio      (o_gpio),
      .o_sw_irq    (o_sw_irq),
      .o_timer_irq (o_timer_irq)
   );

   ssd_controller u_ssdcon (
      .i_clk     (i_clk),
      .i_arst_n  (i_arst_n),
      .i_stb     (ssd_stb),
      .i_cyc     (bus_cyc),
      .i_we      (bus_we),
      .i_wdat    (bus_dat_w),
      .i_sel     (bus_sel),
      .o_rdat    (ssd_rdat),
      .o_ack     (ssd_ack),
      .o_anode   (o_anode),
      .o_cathode (o_cathode)
   );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset source
// 20 ns clock, active-low reset held for the first 10 cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic o_clk,
   output logic o_arst_n
);

   localparam int RESET_CYCLES = 10;

   initial begin
      o_clk    = 1'b0;
      o_arst_n = 1'b0;
      forever #10 o_clk = ~o_clk;
   end

   initial begin
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verification/tb_swervolf_core.sv
// Testbench for the peripheral subsystem
// Host handshake tasks, reference models, compare process
// Watchdog and closing summary

`timescale 1ns/100ps
`default_nettype none

module tb_swervolf_core import swervolf_pkg::*; ();

   localparam int ACK_LIMIT       = 16;
   // Upper bound on the run length in clock cycles
   localparam int WATCHDOG_CYCLES = 20000;
   localparam int SCAN_CYCLES     = 2 * SSD_NUM_DIGITS * (1 << SCAN_DIV_BITS);

   logic       clk;
   logic       arst_n;
   logic       req;
   logic       we;
   addr_t      addr;
   data_t      wdata;
   sel_t       sel;
   gpio_t      gpio_in;
   logic       ack;
   logic       err_o;
   data_t      rdata_o;
   gpio_t      gpio_o;
   logic       timer_irq;
   sw_irq_t    sw_irq;
   logic [7:0] anode;
   logic [7:0] cathode;

   data_t      rom_image [ROM_WORDS];
   string      cmp_name [$];
   data_t      cmp_got [$];
   data_t      cmp_exp [$];
   string      cur_name;
   data_t      cur_got;
   data_t      cur_exp;
   string      cur_test;
   int         n_checks;
   int         n_errors;
   int         errs_at_start;

   tb_clock_gen u_clk_gen (
      .o_clk    (clk),
      .o_arst_n (arst_n)
   );

   swervolf_core dut (
      .i_clk       (clk),
      .i_arst_n    (arst_n),
      .i_req       (req),
      .i_we        (we),
      .i_addr      (addr),
      .i_wdata     (wdata),
      .i_sel       (sel),
      .o_ack       (ack),
      .o_err       (err_o),
      .o_rdata     (rdata_o),
      .i_gpio      (gpio_in),
      .o_gpio      (gpio_o),
      .o_timer_irq (timer_irq),
      .o_sw_irq    (sw_irq),
      .o_anode     (anode),
      .o_cathode   (cathode)
   );

   initial begin
      $readmemh(BOOTROM_FILE, rom_image);
   end

   //**************************************************
   // Reference models
   //**************************************************
   function automatic data_t rom_word(input int idx);
      return rom_image[idx];
   endfunction

   function automatic data_t lane_merge(input data_t old_v, input data_t new_v, input sel_t s);
      data_t mask;
      mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
      return (old_v & ~mask) | (new_v & mask);
   endfunction

   // Active-low cathode patterns with the dp off in bit 7
   function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
      logic [7:0] table_v [16];
      table_v = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                  8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
      return table_v[digit];
   endfunction

   function automatic int low_anode(input logic [7:0] an);
      int idx;
      idx = -1;
      for (int b = SSD_NUM_DIGITS - 1; b >= 0; b--) begin
         if (!an[b])
            idx = b;
      end
      return idx;
   endfunction

   function automatic addr_t rom_addr(input int idx);
      return {REGION_ROM, 6'd0, idx[3:0], 2'b00};
   endfunction

   function automatic addr_t sys_addr(input logic [7:0] offset);
      return {REGION_SYS, 4'h0, offset};
   endfunction

   //**************************************************
   // Checking
   //**************************************************
   task automatic expect_eq(input string name, input data_t got, input data_t exp);
      cmp_name.push_back(name);
      cmp_got.push_back(got);
      cmp_exp.push_back(exp);
   endtask

   task automatic check_true(input logic cond, input string msg);
      n_checks++;
      assert (cond) else begin
         $display("ERROR: %s", msg);
         n_errors++;
      end
   endtask

   // Compare process drains queued results every cycle
   always @(negedge clk) begin
      while (cmp_name.size() != 0) begin
         cur_name = cmp_name.pop_front();
         cur_got  = cmp_got.pop_front();
         cur_exp  = cmp_exp.pop_front();
         n_checks++;
         assert (cur_got === cur_exp) else begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", cur_name, cur_got, cur_exp);
            n_errors++;
         end
      end
   end

   task automatic start_test(input string name);
      cur_test      = name;
      errs_at_start = n_errors;
   endtask

   task automatic end_test();
      @(posedge clk);
      while (cmp_name.size() != 0)
         @(posedge clk);
      $display("test %-12s done, %0d errors", cur_test, n_errors - errs_at_start);
   endtask

   //**************************************************
   // Host handshake
   //**************************************************
   task automatic host_access(input logic a_we, input addr_t a_addr, input data_t a_wdata,
                              input sel_t a_sel, input int hold,
                              output data_t rd, output logic err);
      int cycles;
      @(posedge clk);
      req   <= 1'b1;
      we    <= a_we;
      addr  <= a_addr;
      wdata <= a_wdata;
      sel   <= a_sel;
      cycles = 0;
      @(negedge clk);
      while (!ack && cycles < ACK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      check_true(ack, $sformatf("no ack for access to 0x%h", a_addr));
      rd  = rdata_o;
      err = err_o;
      // Response must hold while req stays high
      repeat (hold) begin
         @(negedge clk);
         expect_eq("o_ack", {31'd0, ack}, 32'd1);
         expect_eq("o_rdata", rdata_o, rd);
      end
      @(posedge clk);
      req <= 1'b0;
      cycles = 0;
      @(negedge clk);
      while (ack && cycles < ACK_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      check_true(!ack, $sformatf("o_ack stuck high after access to 0x%h", a_addr));
   endtask

   task automatic read_word(input addr_t a_addr, output data_t rd);
      logic err;
      host_access(1'b0, a_addr, '0, 4'hF, 0, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd0);
   endtask

   task automatic write_word(input addr_t a_addr, input data_t data, input sel_t s);
      data_t rd;
      logic  err;
      host_access(1'b1, a_addr, data, s, 0, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd0);
   endtask

   //**************************************************
   // Stimulus
   //**************************************************
   initial begin
      int         seed;
      int         hold;
      int         k;
      data_t      rd;
      data_t      val;
      data_t      t1;
      data_t      t2;
      data_t      gpio_model;
      data_t      ssd_model;
      sel_t       s;
      logic       err;
      logic [7:0] seen;
      logic [7:0] anode_exp;

      seed     = $urandom(32'hfe42);
      n_checks = 0;
      n_errors = 0;
      req     <= 1'b0;
      we      <= 1'b0;
      addr    <= '0;
      wdata   <= '0;
      sel     <= '0;
      gpio_in <= '0;
      wait (arst_n === 1'b1);

      start_test("boot_rom");
      for (int i = 0; i < ROM_WORDS; i++) begin
         read_word(rom_addr(i), rd);
         expect_eq("o_rdata", rd, rom_word(i));
      end
      write_word(rom_addr(3), ~rom_word(3), 4'hF);
      read_word(rom_addr(3), rd);
      expect_eq("o_rdata", rd, rom_word(3));
      end_test();

      start_test("gpio");
      gpio_model = '0;
      repeat (8) begin
         val = $urandom;
         s   = sel_t'($urandom_range(15, 0));
         write_word(sys_addr(SYS_GPIO_OUT), val, s);
         gpio_model = lane_merge(gpio_model, val, s);
         read_word(sys_addr(SYS_GPIO_OUT), rd);
         expect_eq("o_rdata", rd, gpio_model);
         expect_eq("o_gpio", gpio_o, gpio_model);
      end
      repeat (4) begin
         val = $urandom;
         @(posedge clk);
         gpio_in <= val;
         read_word(sys_addr(SYS_GPIO_IN), rd);
         expect_eq("o_rdata", rd, val);
      end
      end_test();

      start_test("sw_irq");
      repeat (6) begin
         val = $urandom;
         write_word(sys_addr(SYS_SW_IRQ), val, 4'h1);
         expect_eq("o_sw_irq", {30'd0, sw_irq}, {30'd0, val[1:0]});
         read_word(sys_addr(SYS_SW_IRQ), rd);
         expect_eq("o_rdata", rd, {30'd0, val[1:0]});
      end
      end_test();

      start_test("timer");
      expect_eq("o_timer_irq", {31'd0, timer_irq}, 32'd0);
      read_word(sys_addr(SYS_MTIME), t1);
      read_word(sys_addr(SYS_MTIME), t2);
      check_true(t2 > t1, "mtime did not increase between two reads");
      write_word(sys_addr(SYS_MTIMECMP), 32'd0, 4'hF);
      expect_eq("o_timer_irq", {31'd0, timer_irq}, 32'd1);
      write_word(sys_addr(SYS_MTIMECMP), 32'hFFFF_FFFF, 4'hF);
      expect_eq("o_timer_irq", {31'd0, timer_irq}, 32'd0);
      read_word(sys_addr(SYS_MTIMECMP), rd);
      expect_eq("o_rdata", rd, 32'hFFFF_FFFF);
      end_test();

      start_test("display");
      ssd_model = $urandom;
      write_word({REGION_SSD, 4'h0, SSD_DIGITS_REG}, ssd_model, 4'hF);
      val = $urandom;
      s   = sel_t'($urandom_range(15, 0));
      write_word({REGION_SSD, 4'h0, SSD_DIGITS_REG}, val, s);
      ssd_model = lane_merge(ssd_model, val, s);
      read_word({REGION_SSD, 4'h0, SSD_DIGITS_REG}, rd);
      expect_eq("o_rdata", rd, ssd_model);
      seen = '0;
      repeat (SCAN_CYCLES) begin
         @(negedge clk);
         k = low_anode(anode);
         if (k < 0) begin
            check_true(1'b0, "no anode driven low during the scan");
         end else begin
            seen[k]   = 1'b1;
            anode_exp = ~(8'h01 << k);
            expect_eq("o_anode", anode, anode_exp);
            expect_eq("o_cathode", cathode, seg_pattern(ssd_model[4*k +: 4]));
         end
      end
      check_true(&seen, "not every digit was selected during the scan");
      end_test();

      start_test("handshake");
      host_access(1'b0, 16'h3000, '0, 4'hF, 0, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd1);
      expect_eq("o_rdata", rd, 32'd0);
      hold = $urandom_range(8, 1);
      host_access(1'b1, 16'hF004, $urandom, 4'hF, hold, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd1);
      hold = $urandom_range(8, 1);
      host_access(1'b0, rom_addr(5), '0, 4'hF, hold, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd0);
      expect_eq("o_rdata", rd, rom_word(5));
      val  = $urandom;
      hold = $urandom_range(8, 1);
      host_access(1'b1, sys_addr(SYS_GPIO_OUT), val, 4'hF, hold, rd, err);
      expect_eq("o_err", {31'd0, err}, 32'd0);
      expect_eq("o_gpio", gpio_o, val);
      end_test();

      $display("summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not complete within %0d clock cycles", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
source/swervolf_pkg.sv
source/host_bridge.sv
source/bus_decoder.sv
source/boot_rom.sv
source/swervolf_syscon.sv
source/ssd_controller.sv
source/swervolf_core.sv
verification/tb_clock_gen.sv
verification/tb_swervolf_core.sv

//--- bootrom.hex
// One 32-bit instruction word per line, hex, word 0 at byte address 0x0000
000010b7
0000a103
00410113
0020a023
fff00193
0030a223
00008067
00000013
deadbeef
12345678
a5a5a5a5
5a5a5a5a
0f0f0f0f
f0f0f0f0
cafe0001
0000006f
